/* list.f */
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_way.sv
rtl/dcache_way_select.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
testbench/dcache_mem_model.sv
testbench/dcache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator
# exit status is 0 only when the testbench passes

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module dcache_tb \
    -f list.f -Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/dcache_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$log"; then
    echo "run passed"
    exit 0
fi

echo "pass message not found in $log"
exit 1

/* testbench/dcache_tb.sv */
// --------------------
// dcache testbench
// table-driven loads and stores checked against a shadow byte memory
// --------------------

`include "dcache_params.svh"

module dcache_tb
    import dcache_pkg::*;
();

    localparam int NUM_STIM = 18;
    localparam int NUM_RAND = 40;
    localparam int TIMEOUT  = 400;  // cycles per wait

    typedef struct packed {
        logic                  op;        // 1 = store
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_BE_W-1:0]   be;
        word_t                 wdata;
        logic                  exp_miss;
        logic [`DC_ADDR_W-1:0] wb_addr;   // zero when no write-back
    } stim_t;

    logic                  clk;
    logic                  rst_n;
    logic                  cpu_req_valid;
    cpu_req_t              cpu_req;
    logic                  cpu_req_ready;
    cpu_rsp_t              cpu_rsp;
    logic                  mem_wr_req;
    logic [`DC_ADDR_W-1:0] mem_wr_addr;
    line_t                 mem_wr_line;
    logic                  mem_wr_rdy;
    logic                  mem_rd_req;
    logic [`DC_ADDR_W-1:0] mem_rd_addr;
    logic                  mem_rd_rdy;
    logic                  mem_rd_valid;
    word_t                 mem_rd_data;

    stim_t                 stim [NUM_STIM];
    logic [7:0]            shadow [logic [`DC_ADDR_W-1:0]];
    integer                seed;
    int                    rd_count;
    int                    wr_count;
    logic [`DC_ADDR_W-1:0] last_rd_addr;
    logic [`DC_ADDR_W-1:0] last_wr_addr;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    dcache_top dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .cpu_req_valid_i (cpu_req_valid),
        .cpu_req_i       (cpu_req),
        .cpu_req_ready_o (cpu_req_ready),
        .cpu_rsp_o       (cpu_rsp),
        .mem_wr_req_o    (mem_wr_req),
        .mem_wr_addr_o   (mem_wr_addr),
        .mem_wr_line_o   (mem_wr_line),
        .mem_wr_rdy_i    (mem_wr_rdy),
        .mem_rd_req_o    (mem_rd_req),
        .mem_rd_addr_o   (mem_rd_addr),
        .mem_rd_rdy_i    (mem_rd_rdy),
        .mem_rd_valid_i  (mem_rd_valid),
        .mem_rd_data_i   (mem_rd_data)
    );

    dcache_mem_model u_mem (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_wr_req_i   (mem_wr_req),
        .mem_wr_addr_i  (mem_wr_addr),
        .mem_wr_line_i  (mem_wr_line),
        .mem_wr_rdy_o   (mem_wr_rdy),
        .mem_rd_req_i   (mem_rd_req),
        .mem_rd_addr_i  (mem_rd_addr),
        .mem_rd_rdy_o   (mem_rd_rdy),
        .mem_rd_valid_o (mem_rd_valid),
        .mem_rd_data_o  (mem_rd_data)
    );

    // --------------------
    // shadow memory
    // --------------------
    function automatic logic [7:0] init_byte(input logic [`DC_ADDR_W-1:0] a);
        return (a[7:0] ^ 8'h5a) + 8'd7 * a[15:8] + 8'd13 * a[23:16] + a[31:24];
    endfunction

    function automatic word_t shadow_word(input logic [`DC_ADDR_W-1:0] a);
        word_t                 w;
        logic [`DC_ADDR_W-1:0] ba;
        for (int b = 0; b < `DC_BE_W; b++) begin
            ba = a + 32'(b);
            w[b*8 +: 8] = shadow.exists(ba) ? shadow[ba] : init_byte(ba);
        end
        return w;
    endfunction

    function automatic line_t shadow_line(input logic [`DC_ADDR_W-1:0] a);
        line_t l;
        for (int w = 0; w < `DC_WORDS; w++) begin
            l[w] = shadow_word(a + 32'(4 * w));
        end
        return l;
    endfunction

    task automatic store_shadow(input logic [`DC_ADDR_W-1:0] a, input logic [`DC_BE_W-1:0] be,
                                input word_t d);
        for (int b = 0; b < `DC_BE_W; b++) begin
            if (be[b]) begin
                shadow[a + 32'(b)] = d[b*8 +: 8];
            end
        end
    endtask

    // --------------------
    // checks
    // --------------------
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    // memory handshakes, seen before the edge updates them
    always @(posedge clk) begin
        if (rst_n && mem_rd_req && mem_rd_rdy) begin
            rd_count++;
            last_rd_addr = mem_rd_addr;
        end
        if (rst_n && mem_wr_req && mem_wr_rdy) begin
            wr_count++;
            last_wr_addr = mem_wr_addr;
            check_line("mem_wr_line_o", mem_wr_line, shadow_line(mem_wr_addr));
        end
    end

    // one request from ready to done, inputs change on the falling edge
    task automatic run_access(input stim_t s, input logic check_timing);
        int    waited;
        int    lat;
        word_t exp_rdata;

        waited = 0;
        while (!cpu_req_ready) begin
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("timeout waiting for the cache to become ready");
            end
            @(negedge clk);
        end
        rd_count      = 0;
        wr_count      = 0;
        exp_rdata     = shadow_word({s.addr[`DC_ADDR_W-1:2], 2'b00});
        cpu_req_valid = 1'b1;
        cpu_req.op    = s.op;
        cpu_req.tag   = s.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
        cpu_req.index = s.addr[4 +: `DC_INDEX_W];
        cpu_req.wsel  = s.addr[2 +: `DC_WSEL_W];
        cpu_req.be    = s.be;
        cpu_req.wdata = s.wdata;
        @(negedge clk);  // accepted on the rising edge before
        cpu_req_valid = 1'b0;
        lat = 1;
        while (!cpu_rsp.done) begin
            if (lat > TIMEOUT) begin
                abort_run($sformatf("timeout waiting for done, address %h", s.addr));
            end
            lat++;
            @(negedge clk);
        end
        if (!s.op) begin
            check_word("cpu_rsp_o.rdata", cpu_rsp.rdata, exp_rdata);
        end
        if (check_timing) begin
            if (!s.exp_miss && lat != 2) begin
                abort_run($sformatf("hit at %h took %0d cycles instead of 2", s.addr, lat));
            end
            if (rd_count != int'(s.exp_miss) || wr_count != int'(s.wb_addr != '0)) begin
                abort_run($sformatf("access at %h made %0d reads and %0d writes, expected %0d/%0d",
                                    s.addr, rd_count, wr_count, s.exp_miss, s.wb_addr != '0));
            end
            if (s.exp_miss) begin
                check_word("mem_rd_addr_o", last_rd_addr, {s.addr[`DC_ADDR_W-1:4], 4'h0});
            end
            if (s.wb_addr != '0) begin
                check_word("mem_wr_addr_o", last_wr_addr, s.wb_addr);
            end
        end else begin
            if (rd_count > 1 || wr_count > rd_count) begin
                abort_run($sformatf("access at %h made %0d reads and %0d writes",
                                    s.addr, rd_count, wr_count));
            end
            // victim sits in the set of the request
            if (wr_count != 0) begin
                check_word("mem_wr_addr_o", word_t'(last_wr_addr[7:0]),
                           word_t'({s.addr[7:4], 4'h0}));
            end
        end
        if (s.op) begin
            store_shadow(s.addr, s.be, s.wdata);
        end
        @(negedge clk);
        if (cpu_rsp.done) begin
            abort_run("done stayed high for more than one cycle");
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        stim_t s;

        seed          = 49;
        rd_count      = 0;
        wr_count      = 0;
        last_rd_addr  = '0;
        last_wr_addr  = '0;
        rst_n         = 1'b0;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;

        // op, address, be, wdata, miss, write-back address
        stim[0]  = '{1'b0, 32'h0000_1014, 4'h0, 32'h0000_0000, 1'b1, 32'h0000_0000};  // cold miss
        stim[1]  = '{1'b0, 32'h0000_101c, 4'h0, 32'h0000_0000, 1'b0, 32'h0000_0000};  // same line
        stim[2]  = '{1'b1, 32'h0000_1018, 4'h3, 32'ha5a5_1234, 1'b0, 32'h0000_0000};
        stim[3]  = '{1'b0, 32'h0000_1018, 4'h0, 32'h0000_0000, 1'b0, 32'h0000_0000};
        stim[4]  = '{1'b1, 32'h0000_4024, 4'hc, 32'hbeef_0000, 1'b1, 32'h0000_0000};  // store miss
        stim[5]  = '{1'b0, 32'h0000_4024, 4'h0, 32'h0000_0000, 1'b0, 32'h0000_0000};
        // three tags on index 3
        stim[6]  = '{1'b1, 32'h0000_1030, 4'hf, 32'h1111_2222, 1'b1, 32'h0000_0000};
        stim[7]  = '{1'b0, 32'h0000_2034, 4'h0, 32'h0000_0000, 1'b1, 32'h0000_0000};
        stim[8]  = '{1'b0, 32'h0000_3038, 4'h0, 32'h0000_0000, 1'b1, 32'h0000_1030};  // dirty
        stim[9]  = '{1'b0, 32'h0000_303c, 4'h0, 32'h0000_0000, 1'b0, 32'h0000_0000};
        stim[10] = '{1'b0, 32'h0000_1030, 4'h0, 32'h0000_0000, 1'b1, 32'h0000_0000};  // clean
        stim[11] = '{1'b1, 32'h0000_1034, 4'h6, 32'h00ab_cd00, 1'b0, 32'h0000_0000};
        stim[12] = '{1'b1, 32'h0000_2030, 4'h1, 32'h0000_00cc, 1'b1, 32'h0000_0000};
        stim[13] = '{1'b0, 32'h0000_1034, 4'h0, 32'h0000_0000, 1'b0, 32'h0000_0000};
        stim[14] = '{1'b0, 32'h0000_3030, 4'h0, 32'h0000_0000, 1'b1, 32'h0000_2030};
        stim[15] = '{1'b0, 32'h0000_2030, 4'h0, 32'h0000_0000, 1'b1, 32'h0000_1030};
        stim[16] = '{1'b0, 32'h0000_1034, 4'h0, 32'h0000_0000, 1'b1, 32'h0000_0000};  // refetched
        stim[17] = '{1'b0, 32'h0000_1018, 4'h0, 32'h0000_0000, 1'b0, 32'h0000_0000};

        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_word("cpu_req_ready_o", word_t'(cpu_req_ready), word_t'(1));
        check_word("cpu_rsp_o.done", word_t'(cpu_rsp.done), word_t'(0));
        check_word("mem_wr_req_o", word_t'(mem_wr_req), word_t'(0));
        check_word("mem_rd_req_o", word_t'(mem_rd_req), word_t'(0));

        for (int i = 0; i < NUM_STIM; i++) begin
            run_access(stim[i], 1'b1);
        end

        // random mix over three tags and two sets
        for (int i = 0; i < NUM_RAND; i++) begin
            s.op       = 1'($random(seed));
            s.addr     = {24'h50 + 24'(($unsigned($random(seed)) % 3) * 16),
                          4'd5 + 4'($unsigned($random(seed)) % 2),
                          2'($random(seed)), 2'b00};
            s.be       = 4'($random(seed));
            s.wdata    = $random(seed);
            s.exp_miss = 1'b0;
            s.wb_addr  = '0;
            run_access(s, 1'b0);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* testbench/dcache_mem_model.sv */
// --------------------
// line memory model
// byte memory behind the cache, random ready and data gaps
// --------------------

`include "dcache_params.svh"

module dcache_mem_model
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_wr_req_i,
    input  logic [`DC_ADDR_W-1:0] mem_wr_addr_i,
    input  line_t                 mem_wr_line_i,
    output logic                  mem_wr_rdy_o,
    input  logic                  mem_rd_req_i,
    input  logic [`DC_ADDR_W-1:0] mem_rd_addr_i,
    output logic                  mem_rd_rdy_o,
    output logic                  mem_rd_valid_o,
    output word_t                 mem_rd_data_o
);

    logic [7:0]            mem_bytes [logic [`DC_ADDR_W-1:0]];
    integer                seed;
    logic [`DC_ADDR_W-1:0] addr;
    line_t                 line;

    // untouched bytes come from the whole address
    function automatic logic [7:0] init_byte(input logic [`DC_ADDR_W-1:0] a);
        return (a[7:0] ^ 8'h5a) + 8'd7 * a[15:8] + 8'd13 * a[23:16] + a[31:24];
    endfunction

    function automatic word_t read_word(input logic [`DC_ADDR_W-1:0] a);
        word_t                 w;
        logic [`DC_ADDR_W-1:0] ba;
        for (int b = 0; b < `DC_BE_W; b++) begin
            ba = a + 32'(b);
            w[b*8 +: 8] = mem_bytes.exists(ba) ? mem_bytes[ba] : init_byte(ba);
        end
        return w;
    endfunction

    // idle for 0..3 falling edges
    task automatic stall();
        int n;
        n = int'($unsigned($random(seed)) % 4);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    initial begin
        seed           = 49;
        mem_wr_rdy_o   = 1'b0;
        mem_rd_rdy_o   = 1'b0;
        mem_rd_valid_o = 1'b0;
        mem_rd_data_o  = '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_wr_req_i) begin
                stall();
                addr         = mem_wr_addr_i;  // held by the cache until ready
                line         = mem_wr_line_i;
                mem_wr_rdy_o = 1'b1;
                @(posedge clk);
                for (int w = 0; w < `DC_WORDS; w++) begin
                    for (int b = 0; b < `DC_BE_W; b++) begin
                        mem_bytes[addr + 32'(4 * w + b)] = line[w][b*8 +: 8];
                    end
                end
                @(negedge clk);
                mem_wr_rdy_o = 1'b0;
            end else if (rst_n && mem_rd_req_i) begin
                stall();
                addr         = mem_rd_addr_i;
                mem_rd_rdy_o = 1'b1;
                @(negedge clk);
                mem_rd_rdy_o = 1'b0;
                // words in order, gaps in between
                for (int w = 0; w < `DC_WORDS; w++) begin
                    stall();
                    mem_rd_valid_o = 1'b1;
                    mem_rd_data_o  = read_word(addr + 32'(4 * w));
                    @(negedge clk);
                    mem_rd_valid_o = 1'b0;
                end
            end
        end
    end

endmodule

/* rtl/dcache_top.sv */
// --------------------
// dcache top
// 2-way write-back data cache, controller plus way array
// --------------------

`include "dcache_params.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // cpu
    input  logic                  cpu_req_valid_i,
    input  cpu_req_t              cpu_req_i,
    output logic                  cpu_req_ready_o,
    output cpu_rsp_t              cpu_rsp_o,
    // memory write
    output logic                  mem_wr_req_o,
    output logic [`DC_ADDR_W-1:0] mem_wr_addr_o,
    output line_t                 mem_wr_line_o,
    input  logic                  mem_wr_rdy_i,
    // memory read
    output logic                  mem_rd_req_o,
    output logic [`DC_ADDR_W-1:0] mem_rd_addr_o,
    input  logic                  mem_rd_rdy_i,
    input  logic                  mem_rd_valid_i,
    input  word_t                 mem_rd_data_i
);

    logic [`DC_INDEX_W-1:0] rd_index;
    way_wr_t                way_wr [`DC_WAYS];
    way_rd_t                way_rd [`DC_WAYS];

    logic                   hit;
    logic                   hit_way;
    word_t                  rd_word;
    logic                   victim_way;
    way_rd_t                victim;
    logic [`DC_TAG_W-1:0]   sel_tag;
    logic [`DC_INDEX_W-1:0] sel_index;
    logic [`DC_WSEL_W-1:0]  sel_wsel;
    logic                   lru_touch;

    dcache_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .cpu_req_valid_i (cpu_req_valid_i),
        .cpu_req_i       (cpu_req_i),
        .cpu_req_ready_o (cpu_req_ready_o),
        .cpu_rsp_o       (cpu_rsp_o),
        .mem_wr_req_o    (mem_wr_req_o),
        .mem_wr_addr_o   (mem_wr_addr_o),
        .mem_wr_line_o   (mem_wr_line_o),
        .mem_wr_rdy_i    (mem_wr_rdy_i),
        .mem_rd_req_o    (mem_rd_req_o),
        .mem_rd_addr_o   (mem_rd_addr_o),
        .mem_rd_rdy_i    (mem_rd_rdy_i),
        .mem_rd_valid_i  (mem_rd_valid_i),
        .mem_rd_data_i   (mem_rd_data_i),
        .rd_index_o      (rd_index),
        .way_wr_o        (way_wr),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .rd_word_i       (rd_word),
        .victim_way_i    (victim_way),
        .victim_i        (victim),
        .tag_o           (sel_tag),
        .index_o         (sel_index),
        .wsel_o          (sel_wsel),
        .lru_touch_o     (lru_touch)
    );

    // one storage block per way
    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        dcache_way u_way (
            .clk        (clk),
            .rst_n      (rst_n),
            .rd_index_i (rd_index),
            .wr_i       (way_wr[w]),
            .rd_o       (way_rd[w])
        );
    end

    dcache_way_select u_way_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .ways_i       (way_rd),
        .tag_i        (sel_tag),
        .index_i      (sel_index),
        .wsel_i       (sel_wsel),
        .lru_touch_i  (lru_touch),
        .hit_o        (hit),
        .hit_way_o    (hit_way),
        .rd_word_o    (rd_word),
        .victim_way_o (victim_way),
        .victim_o     (victim)
    );

endmodule

/* rtl/dcache_ctrl.sv */
// --------------------
// dcache controller
// FSM, request buffer, way write commands,
// memory requests and the done response
// --------------------

`include "dcache_params.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    // cpu side
    input  logic                   cpu_req_valid_i,
    input  cpu_req_t               cpu_req_i,
    output logic                   cpu_req_ready_o,
    output cpu_rsp_t               cpu_rsp_o,
    // memory side
    output logic                   mem_wr_req_o,
    output logic [`DC_ADDR_W-1:0]  mem_wr_addr_o,
    output line_t                  mem_wr_line_o,
    input  logic                   mem_wr_rdy_i,
    output logic                   mem_rd_req_o,
    output logic [`DC_ADDR_W-1:0]  mem_rd_addr_o,
    input  logic                   mem_rd_rdy_i,
    input  logic                   mem_rd_valid_i,
    input  word_t                  mem_rd_data_i,
    // ways
    output logic [`DC_INDEX_W-1:0] rd_index_o,
    output way_wr_t                way_wr_o [`DC_WAYS],
    // way select
    input  logic                   hit_i,
    input  logic                   hit_way_i,
    input  word_t                  rd_word_i,
    input  logic                   victim_way_i,
    input  way_rd_t                victim_i,
    output logic [`DC_TAG_W-1:0]   tag_o,
    output logic [`DC_INDEX_W-1:0] index_o,
    output logic [`DC_WSEL_W-1:0]  wsel_o,
    output logic                   lru_touch_o
);

    localparam int OFS_W = `DC_ADDR_W - `DC_TAG_W - `DC_INDEX_W;

    ctrl_state_t              state_q;
    ctrl_state_t              state_d;
    cpu_req_t                 req_q;
    logic                     victim_q;           // way picked at the miss
    logic [`DC_WSEL_W:0]      refill_cnt_q;       // msb set = all words in
    logic                     done_q;
    word_t                    rdata_q;

    logic accept;
    logic lookup_hit;
    logic refill_wr;

    assign accept     = (state_q == IDLE) && cpu_req_valid_i;
    assign lookup_hit = (state_q == LOOKUP) && hit_i;
    assign refill_wr  = (state_q == REFILL) && mem_rd_valid_i && !refill_cnt_q[`DC_WSEL_W];

    // --------------------
    // next state
    // --------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:       if (cpu_req_valid_i) state_d = LOOKUP;
            LOOKUP: begin
                if (hit_i) begin
                    state_d = IDLE;
                end else if (victim_i.valid && victim_i.dirty) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL_REQ;
                end
            end
            WRITEBACK:  if (mem_wr_rdy_i) state_d = REFILL_REQ;
            REFILL_REQ: if (mem_rd_rdy_i) state_d = REFILL;
            REFILL:     if (refill_cnt_q[`DC_WSEL_W]) state_d = LOOKUP;  // replay
            default:    state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            victim_q     <= 1'b0;
            refill_cnt_q <= '0;
            done_q       <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= lookup_hit;
            if (state_q == LOOKUP && !hit_i) begin
                victim_q <= victim_way_i;
            end
            if (state_q == REFILL_REQ) begin
                refill_cnt_q <= '0;
            end else if (refill_wr) begin
                refill_cnt_q <= refill_cnt_q + 1'b1;
            end
        end
    end

    // request buffer and read data
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= cpu_req_i;
        end
        if (lookup_hit) begin
            rdata_q <= rd_word_i;
        end
    end

    // --------------------
    // way write commands
    // --------------------
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_wr_o[w]       = '0;
            way_wr_o[w].index = req_q.index;
            way_wr_o[w].tag   = req_q.tag;
            if (lookup_hit && req_q.op && hit_way_i == 1'(w)) begin
                way_wr_o[w].meta_en = 1'b1;        // store hit marks the line dirty
                way_wr_o[w].dirty   = 1'b1;
                way_wr_o[w].be      = req_q.be;
                way_wr_o[w].wsel    = req_q.wsel;
                way_wr_o[w].wdata   = req_q.wdata;
            end else if (refill_wr && victim_q == 1'(w)) begin
                way_wr_o[w].be      = '1;
                way_wr_o[w].wsel    = refill_cnt_q[`DC_WSEL_W-1:0];
                way_wr_o[w].wdata   = mem_rd_data_i;
                // last word also installs the tag, clean
                way_wr_o[w].meta_en = (refill_cnt_q[`DC_WSEL_W-1:0] == '1);
            end
        end
    end

    // --------------------
    // outputs
    // --------------------
    assign rd_index_o  = (state_q == IDLE) ? cpu_req_i.index : req_q.index;
    assign tag_o       = req_q.tag;
    assign index_o     = req_q.index;
    assign wsel_o      = req_q.wsel;
    assign lru_touch_o = lookup_hit;

    assign cpu_req_ready_o = (state_q == IDLE);
    assign cpu_rsp_o.done  = done_q;
    assign cpu_rsp_o.rdata = rdata_q;

    // requests held by the state until the handshake edge
    assign mem_wr_req_o  = (state_q == WRITEBACK);
    assign mem_wr_addr_o = {victim_i.tag, req_q.index, {OFS_W{1'b0}}};
    assign mem_wr_line_o = victim_i.line;
    assign mem_rd_req_o  = (state_q == REFILL_REQ);
    assign mem_rd_addr_o = {req_q.tag, req_q.index, {OFS_W{1'b0}}};

endmodule

/* rtl/dcache_way_select.sv */
// --------------------
// dcache way select
// tag compare, word mux, per-set LRU and victim choice
// --------------------

`include "dcache_params.svh"

module dcache_way_select
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  way_rd_t                ways_i [`DC_WAYS],
    input  logic [`DC_TAG_W-1:0]   tag_i,
    input  logic [`DC_INDEX_W-1:0] index_i,
    input  logic [`DC_WSEL_W-1:0]  wsel_i,
    input  logic                   lru_touch_i,
    output logic                   hit_o,
    output logic                   hit_way_o,
    output word_t                  rd_word_o,
    output logic                   victim_way_o,
    output way_rd_t                victim_o
);

    // bit per set names the way to evict next
    logic [`DC_SETS-1:0] lru_q;

    // --------------------
    // hit detection
    // --------------------
    always_comb begin
        hit_o     = 1'b0;
        hit_way_o = 1'b0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (ways_i[w].valid && (ways_i[w].tag == tag_i)) begin
                hit_o     = 1'b1;
                hit_way_o = 1'(w);
            end
        end
    end

    assign rd_word_o = ways_i[hit_way_o].line[wsel_i];

    // --------------------
    // victim choice
    // --------------------
    always_comb begin
        victim_way_o = lru_q[index_i];
        // lowest invalid way wins over LRU
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (!ways_i[w].valid) begin
                victim_way_o = 1'(w);
            end
        end
    end

    assign victim_o = ways_i[victim_way_o];

    // --------------------
    // LRU update
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_q <= '0;
        end else if (lru_touch_i) begin
            lru_q[index_i] <= ~hit_way_o;  // other way becomes oldest
        end
    end

endmodule

/* rtl/dcache_way.sv */
// --------------------
// dcache way storage
// tag, valid, dirty and data arrays of one way
// byte-wise writes, registered read port
// --------------------

`include "dcache_params.svh"

module dcache_way
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`DC_INDEX_W-1:0] rd_index_i,
    input  way_wr_t                wr_i,
    output way_rd_t                rd_o
);

    localparam int BYTE_W = `DC_WORD_W / `DC_BE_W;

    logic [`DC_TAG_W-1:0] tag_mem   [`DC_SETS];
    line_t                data_mem  [`DC_SETS];
    logic                 dirty_mem [`DC_SETS];
    logic [`DC_SETS-1:0]  valid_q;

    logic                 rd_valid_q;
    logic                 rd_dirty_q;
    logic [`DC_TAG_W-1:0] rd_tag_q;
    line_t                rd_line_q;

    // --------------------
    // write side
    // --------------------
    always_ff @(posedge clk) begin
        for (int b = 0; b < `DC_BE_W; b++) begin
            if (wr_i.be[b]) begin
                data_mem[wr_i.index][wr_i.wsel][b*BYTE_W +: BYTE_W] <=
                    wr_i.wdata[b*BYTE_W +: BYTE_W];
            end
        end
        if (wr_i.meta_en) begin
            tag_mem[wr_i.index]   <= wr_i.tag;
            dirty_mem[wr_i.index] <= wr_i.dirty;
        end
    end

    // valid bits, all lines empty after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_i.meta_en) begin
            valid_q[wr_i.index] <= 1'b1;
        end
    end

    // --------------------
    // read side
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= valid_q[rd_index_i];
        end
    end

    always_ff @(posedge clk) begin
        rd_dirty_q <= dirty_mem[rd_index_i];  // old value on same-edge write
        rd_tag_q   <= tag_mem[rd_index_i];
        rd_line_q  <= data_mem[rd_index_i];
    end

    assign rd_o.valid = rd_valid_q;
    assign rd_o.dirty = rd_dirty_q;
    assign rd_o.tag   = rd_tag_q;
    assign rd_o.line  = rd_line_q;

endmodule

/* rtl/dcache_pkg.sv */
// --------------------
// data cache types
// request, response and way command structs, FSM states
// --------------------

`include "dcache_params.svh"

package dcache_pkg;

    typedef logic [`DC_WORD_W-1:0] word_t;

    // line is word-addressable, word 0 in the low bits
    typedef logic [`DC_WORDS-1:0][`DC_WORD_W-1:0] line_t;

    typedef struct packed {
        logic                   op;     // 1 = store
        logic [`DC_TAG_W-1:0]   tag;
        logic [`DC_INDEX_W-1:0] index;
        logic [`DC_WSEL_W-1:0]  wsel;
        logic [`DC_BE_W-1:0]    be;
        word_t                  wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  done;
        word_t rdata;
    } cpu_rsp_t;

    // write command into one way
    typedef struct packed {
        logic                   meta_en;  // tag, valid and dirty
        logic [`DC_BE_W-1:0]    be;
        logic [`DC_INDEX_W-1:0] index;
        logic [`DC_WSEL_W-1:0]  wsel;
        logic [`DC_TAG_W-1:0]   tag;
        logic                   dirty;
        word_t                  wdata;
    } way_wr_t;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [`DC_TAG_W-1:0] tag;
        line_t                line;
    } way_rd_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL_REQ,
        REFILL
    } ctrl_state_t;

endpackage

/* rtl/dcache_params.svh */
// --------------------
// data cache geometry
// sizes and widths shared by package and RTL
// --------------------

`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// organisation
`define DC_WAYS    2
`define DC_SETS    16
`define DC_WORDS   4   // words per line

// field widths
`define DC_INDEX_W 4
`define DC_WSEL_W  2
`define DC_TAG_W   24

// datapath
`define DC_WORD_W  32
`define DC_BE_W    4   // one enable per byte
`define DC_ADDR_W  32  // byte address

`endif
